//--- source/booth_arith_pkg.sv
// Unsigned 24x24 mantissa product only; widths are fixed by the format and are not meant to change
package booth_arith_pkg;

  //////////////////////////////
  // Operand and product widths
  //////////////////////////////

  localparam int OPND_W      = 24;              // Mantissa incl. hidden bit
  localparam int PROD_W      = 2 * OPND_W;      // Full product, no rounding
  localparam int NUM_DIGITS  = OPND_W / 2 + 1;  // 13 radix-4 digits
  localparam int DIGIT_IDX_W = 4;               // Enough for index 0..12

  // Last digit sees {0, 0, b[23]} so its negate bit is always 0
  localparam int LAST_DIGIT  = NUM_DIGITS - 1;

  //////////////////////////////
  // Final adder geometry
  //////////////////////////////

  localparam int ADD_BLK_W   = 4;                    // Ripple block width
  localparam int ADD_NBLK    = PROD_W / ADD_BLK_W;   // 12 blocks
  localparam int ADD_KS_LVLS = $clog2(ADD_NBLK);     // Prefix levels over blocks

  //////////////////////////////
  // Datapath types
  //////////////////////////////

  // Booth select lines for one digit
  typedef struct packed {
    logic one;   // Select A
    logic two;   // Select 2A
    logic neg;   // Invert, +1 folded into a later row
  } booth_sel_t;

  // One product-width row
  typedef logic [PROD_W-1:0] row_t;

  // Redundant accumulator state
  typedef struct packed {
    row_t sum;     // Bitwise sum word
    row_t carry;   // Carry word, already shifted to its weight
  } csa_pair_t;

endpackage

//--- source/mul_apb_pkg.sv
// APB subset with pready tied high and no pprot/pstrb; registers sit at word offsets of an 8-bit address
package mul_apb_pkg;

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam logic [APB_ADDR_W-1:0] ADDR_OP_A   = 8'h00;  // Multiplicand
  localparam logic [APB_ADDR_W-1:0] ADDR_OP_B   = 8'h04;  // Multiplier
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 8'h08;  // Write only, reads 0
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 8'h0C;  // Read only
  localparam logic [APB_ADDR_W-1:0] ADDR_RES_LO = 8'h10;  // Product 31:0
  localparam logic [APB_ADDR_W-1:0] ADDR_RES_HI = 8'h14;  // Product 47:32

  localparam int CTRL_START_BIT  = 0;
  localparam int STAT_BUSY_BIT   = 0;
  localparam int STAT_DONE_BIT   = 1;

  // Requester side of the bus
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // Completer side of the bus
  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

//--- source/booth_pp_gen.sv
// Combinational; op_a must be held stable while digits are being stepped
`timescale 1ns/1ns

module booth_pp_gen (
  input  logic [booth_arith_pkg::OPND_W-1:0]      op_a,
  input  logic [2:0]                              window,     // b[2i+1], b[2i], b[2i-1]
  input  logic [booth_arith_pkg::DIGIT_IDX_W-1:0] digit_idx,
  output booth_arith_pkg::row_t                   row,
  output logic                                    neg
);

  import booth_arith_pkg::*;

  booth_sel_t      sel;
  logic [OPND_W:0] mag;       // 0, A or 2A
  logic [OPND_W:0] pp;        // Magnitude, one's complemented for negative digits
  row_t            row_ext;   // Sign-extended row at weight 1

  //////////////////////////////
  // Booth encoder
  //////////////////////////////

  always_comb
  begin
    sel.one = window[1] ^ window[0];                   // Digit is +-1
    sel.two = (window[2] ^ window[1]) & ~sel.one;      // Digit is +-2
    sel.neg = window[2];                               // Raw sign, 111 gives -0
  end

  //////////////////////////////
  // Row generation
  //////////////////////////////

  always_comb
  begin
    mag = '0;
    if (sel.one)
    begin
      mag = {1'b0, op_a};
    end
    else if (sel.two)
    begin
      mag = {op_a, 1'b0};
    end
  end

  // Two's complement without the +1
  assign pp = mag ^ {(OPND_W + 1){sel.neg}};

  // Sign extension up to the product width
  assign row_ext = {{(PROD_W - OPND_W - 1){sel.neg}}, pp};

  // Weight 4^i, bits that fall off the top do not matter modulo 2^48
  assign row = row_ext << {digit_idx, 1'b0};

  // The missing +1 travels to the accumulator
  assign neg = sel.neg;

endmodule

//--- source/csa_accumulator.sv
// One row per step in carry-save form; product only changes on finish and holds otherwise
`timescale 1ns/1ns

module csa_accumulator (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       clear,     // Start of a new operation
  input  logic                       step,      // Add one Booth row
  input  logic                       finish,    // Capture resolved sum
  input  booth_arith_pkg::row_t      row,
  input  logic                       neg,       // +1 owed by the current row
  input  booth_arith_pkg::row_t      sum_in,    // From the final adder
  output booth_arith_pkg::csa_pair_t acc,
  output booth_arith_pkg::row_t      product
);

  import booth_arith_pkg::*;

  row_t pos_q;      // One-hot weight 4^i of the current digit
  logic neg_pend;   // Negate bit of the previous digit
  row_t row_in;     // Row with the owed +1 folded in
  row_t maj;        // 3:2 carry before the shift

  // Bit 2(i-1) is always zero in row i, so the previous +1 fits there
  assign row_in = row | ((pos_q >> 2) & {PROD_W{neg_pend}});

  assign maj = (acc.sum & acc.carry) | (acc.sum & row_in) | (acc.carry & row_in);

  //////////////////////////////
  // Carry-save state
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (clear)
    begin
      acc <= '0;
    end
    else if (step)
    begin
      acc.sum   <= acc.sum ^ acc.carry ^ row_in;
      acc.carry <= {maj[PROD_W-2:0], 1'b0};   // Carry out of bit 47 is dropped
    end
  end

  // Digit weight tracking and the result register
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pos_q    <= '0;
      neg_pend <= 1'b0;
      product  <= '0;
    end
    else
    begin
      if (clear)
      begin
        pos_q    <= row_t'(1);
        neg_pend <= 1'b0;
      end
      else if (step)
      begin
        pos_q    <= pos_q << 2;
        neg_pend <= neg;      // Paid back on the next step
      end
      if (finish)
      begin
        product <= sum_in;
      end
    end
  end

endmodule

//--- source/sparse_ks_adder.sv
// Combinational 48-bit adder, no carry in; the carry out of bit 47 is not produced
`timescale 1ns/1ns

module sparse_ks_adder (
  input  booth_arith_pkg::row_t a,
  input  booth_arith_pkg::row_t b,
  output booth_arith_pkg::row_t sum
);

  import booth_arith_pkg::*;

  row_t                g0;                    // Bit generate
  row_t                p0;                    // Bit propagate
  logic [PROD_W/2-1:0] g1;                    // Pair generate
  logic [PROD_W/2-1:0] p1;
  logic [ADD_NBLK-1:0] bg [0:ADD_KS_LVLS];    // Block generate per prefix level
  logic [ADD_NBLK-1:0] bp [0:ADD_KS_LVLS];
  logic [ADD_NBLK-1:0] cblk;                  // Carry into each 4-bit block
  row_t                cbit;                  // Carry into each bit

  assign g0 = a & b;
  assign p0 = a ^ b;

  //////////////////////////////
  // Block G/P and prefix tree
  //////////////////////////////

  always_comb
  begin
    for (int i = 0; i < PROD_W / 2; i++)
    begin
      p1[i] = p0[2*i+1] & p0[2*i];
      g1[i] = g0[2*i+1] | (p0[2*i+1] & g0[2*i]);
    end
    for (int k = 0; k < ADD_NBLK; k++)
    begin
      bp[0][k] = p1[2*k+1] & p1[2*k];
      bg[0][k] = g1[2*k+1] | (p1[2*k+1] & g1[2*k]);
    end
    // Kogge-Stone over blocks, span doubles each level
    for (int l = 0; l < ADD_KS_LVLS; l++)
    begin
      for (int k = 0; k < ADD_NBLK; k++)
      begin
        if (k >= (1 << l))
        begin
          bg[l+1][k] = bg[l][k] | (bp[l][k] & bg[l][k-(1<<l)]);
          bp[l+1][k] = bp[l][k] & bp[l][k-(1<<l)];
        end
        else
        begin
          bg[l+1][k] = bg[l][k];   // Already complete
          bp[l+1][k] = bp[l][k];
        end
      end
    end
  end

  // Block k receives the group carry of blocks 0..k-1
  assign cblk = {bg[ADD_KS_LVLS][ADD_NBLK-2:0], 1'b0};

  //////////////////////////////
  // 4-bit ripple blocks
  //////////////////////////////

  always_comb
  begin
    for (int k = 0; k < ADD_NBLK; k++)
    begin
      cbit[ADD_BLK_W*k] = cblk[k];
      for (int j = 1; j < ADD_BLK_W; j++)
      begin
        cbit[ADD_BLK_W*k+j] = g0[ADD_BLK_W*k+j-1] |
                              (p0[ADD_BLK_W*k+j-1] & cbit[ADD_BLK_W*k+j-1]);
      end
    end
  end

  assign sum = p0 ^ cbit;

endmodule

//--- source/mul_sequencer.sv
// Fixed 15-cycle run per start; start is ignored unless idle or done
`timescale 1ns/1ns

module mul_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic start,    // One-cycle pulse from the register block
  input  logic last,     // Digit 12 is being stepped
  output logic clear,
  output logic step,
  output logic finish,
  output logic busy,
  output logic done
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CLEAR,    // Load multiplier, zero accumulator
    S_ACCUM,    // One Booth digit per cycle
    S_FINISH,   // Capture adder output
    S_DONE      // Result valid until next start
  } state_t;

  state_t state, state_nxt;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= S_IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      S_IDLE   : if (start) state_nxt = S_CLEAR;
      S_CLEAR  : state_nxt = S_ACCUM;
      S_ACCUM  : if (last) state_nxt = S_FINISH;   // 13th step is this cycle
      S_FINISH : state_nxt = S_DONE;
      S_DONE   : if (start) state_nxt = S_CLEAR;   // Re-run drops done
      default  : state_nxt = S_IDLE;
    endcase
  end

  // Moore outputs
  assign clear  = (state == S_CLEAR);
  assign step   = (state == S_ACCUM);
  assign finish = (state == S_FINISH);
  assign busy   = clear | step | finish;
  assign done   = (state == S_DONE);

endmodule

//--- source/booth_digit_counter.sv
// Multiplier is taken on clear; later changes to op_b do not affect a running operation
`timescale 1ns/1ns

module booth_digit_counter (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    clear,
  input  logic                                    step,
  input  logic [booth_arith_pkg::OPND_W-1:0]      op_b,
  output logic [2:0]                              window,
  output logic [booth_arith_pkg::DIGIT_IDX_W-1:0] digit_idx,
  output logic                                    last
);

  import booth_arith_pkg::*;

  logic [OPND_W+2:0] win_sr;   // {00, b, 0}, two zeros pad the last group

  always_ff @(posedge clk)
  begin
    if (clear)
    begin
      win_sr <= {2'b00, op_b, 1'b0};
    end
    else if (step)
    begin
      win_sr <= win_sr >> 2;   // Next overlapping triplet
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      digit_idx <= '0;
    end
    else if (clear)
    begin
      digit_idx <= '0;
    end
    else if (step)
    begin
      digit_idx <= digit_idx + 1'b1;
    end
  end

  assign window = win_sr[2:0];
  assign last   = (digit_idx == DIGIT_IDX_W'(LAST_DIGIT));

endmodule

//--- source/apb_mul_regs.sv
// Zero wait states; operand and start writes are refused with pslverr while busy
`timescale 1ns/1ns

module apb_mul_regs (
  input  logic                               clk,
  input  logic                               reset,
  input  mul_apb_pkg::apb_req_t              apb_req,
  input  logic                               busy,
  input  logic                               done,
  input  booth_arith_pkg::row_t              product,
  output mul_apb_pkg::apb_rsp_t              apb_rsp,
  output logic [booth_arith_pkg::OPND_W-1:0] op_a,
  output logic [booth_arith_pkg::OPND_W-1:0] op_b,
  output logic                               start
);

  import booth_arith_pkg::*;
  import mul_apb_pkg::*;

  logic                  access;     // Second cycle of a transfer
  logic                  hit_op;     // Operand registers
  logic                  hit_ctrl;
  logic                  hit_ro;     // Status and result
  logic                  err;
  logic                  wr_ok;      // Write that takes effect
  logic [APB_DATA_W-1:0] rd_word;

  //////////////////////////////
  // Decode and error rules
  //////////////////////////////

  assign access   = apb_req.psel & apb_req.penable;
  assign hit_op   = (apb_req.paddr == ADDR_OP_A) | (apb_req.paddr == ADDR_OP_B);
  assign hit_ctrl = (apb_req.paddr == ADDR_CTRL);
  assign hit_ro   = (apb_req.paddr == ADDR_STATUS) | (apb_req.paddr == ADDR_RES_LO) |
                    (apb_req.paddr == ADDR_RES_HI);

  assign err = ~(hit_op | hit_ctrl | hit_ro)                    // Unmapped
             | (apb_req.pwrite & hit_ro)                        // Read-only target
             | (apb_req.pwrite & busy & (hit_op | hit_ctrl));   // Operation in flight

  assign wr_ok = access & apb_req.pwrite & ~err;
  assign start = wr_ok & hit_ctrl & apb_req.pwdata[CTRL_START_BIT];

  // Operand registers
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      op_a <= '0;
      op_b <= '0;
    end
    else if (wr_ok)
    begin
      if (apb_req.paddr == ADDR_OP_A)
      begin
        op_a <= apb_req.pwdata[OPND_W-1:0];
      end
      if (apb_req.paddr == ADDR_OP_B)
      begin
        op_b <= apb_req.pwdata[OPND_W-1:0];
      end
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  always_comb
  begin
    rd_word = '0;   // CTRL and misses read as 0
    case (apb_req.paddr)
      ADDR_OP_A   : rd_word = {{(APB_DATA_W - OPND_W){1'b0}}, op_a};
      ADDR_OP_B   : rd_word = {{(APB_DATA_W - OPND_W){1'b0}}, op_b};
      ADDR_STATUS :
      begin
        rd_word[STAT_BUSY_BIT] = busy;
        rd_word[STAT_DONE_BIT] = done;
      end
      ADDR_RES_LO : rd_word = product[APB_DATA_W-1:0];
      ADDR_RES_HI : rd_word = {{(2*APB_DATA_W - PROD_W){1'b0}}, product[PROD_W-1:APB_DATA_W]};
      default     : rd_word = '0;
    endcase
  end

  assign apb_rsp.prdata  = (access & ~apb_req.pwrite & ~err) ? rd_word : '0;
  assign apb_rsp.pready  = 1'b1;           // No wait states
  assign apb_rsp.pslverr = access & err;

endmodule

//--- source/booth_mul_apb.sv
// One multiplication in flight; done follows a start write by exactly 15 clocks
`timescale 1ns/1ns

module booth_mul_apb (
  input  logic                  clk,
  input  logic                  reset,
  input  mul_apb_pkg::apb_req_t apb_req,
  output mul_apb_pkg::apb_rsp_t apb_rsp
);

  import booth_arith_pkg::*;

  logic [OPND_W-1:0]      op_a;
  logic [OPND_W-1:0]      op_b;
  logic                   start;
  logic                   busy;
  logic                   done;
  logic                   clear;
  logic                   step;
  logic                   finish;
  logic                   last;
  logic [2:0]             window;      // Current Booth triplet
  logic [DIGIT_IDX_W-1:0] digit_idx;
  row_t                   row;         // Weighted partial product
  logic                   neg;
  csa_pair_t              acc;
  row_t                   sum;         // Resolved accumulator
  row_t                   product;

  apb_mul_regs u_regs (
    .clk, .reset, .apb_req, .busy, .done, .product,
    .apb_rsp, .op_a, .op_b, .start
  );

  mul_sequencer u_seq (
    .clk, .reset, .start, .last, .clear, .step, .finish, .busy, .done
  );

  booth_digit_counter u_cnt (
    .clk, .reset, .clear, .step, .op_b, .window, .digit_idx, .last
  );

  booth_pp_gen u_ppg (
    .op_a, .window, .digit_idx, .row, .neg
  );

  csa_accumulator u_acc (
    .clk, .reset, .clear, .step, .finish, .row, .neg,
    .sum_in (sum),
    .acc, .product
  );

  sparse_ks_adder u_add (
    .a   (acc.sum),
    .b   (acc.carry),
    .sum (sum)
  );

endmodule

//--- sim/booth_mul_assertions.sv
// Bound into booth_mul_apb; inputs must change away from the rising edge for clean sampling
`timescale 1ns/1ns

module booth_mul_assertions (
  input logic                  clk,
  input logic                  reset,
  input mul_apb_pkg::apb_req_t apb_req,
  input mul_apb_pkg::apb_rsp_t apb_rsp,
  input logic                  busy,
  input logic                  done,
  input booth_arith_pkg::row_t product
);

  int fail_cnt = 0;   // Failed assertions so far

  //////////////////////////////
  // Bus and status properties
  //////////////////////////////

  // Zero wait states
  pready_high: assert property (@(posedge clk) disable iff (reset) apb_rsp.pready)
  else
  begin
    $error("pready low at %0t", $time);
    fail_cnt++;
  end

  busy_done_excl: assert property (@(posedge clk) disable iff (reset) !(busy && done))
  else
  begin
    $error("busy and done both high");
    fail_cnt++;
  end

  // Error only in the second cycle of a transfer
  err_in_access: assert property (@(posedge clk) disable iff (reset)
    apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
  else
  begin
    $error("pslverr outside an access phase");
    fail_cnt++;
  end

  result_stable: assert property (@(posedge clk) disable iff (reset)
    (done && $past(done)) |-> $stable(product))
  else
  begin
    $error("product moved while done");
    fail_cnt++;
  end

endmodule

//--- sim/booth_mul_tb.sv
// Run from the project root so that sim/mul_cases.txt is found; one operation in flight at a time
`timescale 1ns/1ns

module booth_mul_tb;

  import booth_arith_pkg::*;
  import mul_apb_pkg::*;

  logic     clk;
  logic     reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  int       cyc = 0;         // Rising edges so far
  int       fail_cnt = 0;    // Value mismatches
  int       other_cnt = 0;   // Timeouts, missing file

  booth_mul_apb uut (.clk, .reset, .apb_req, .apb_rsp);

  bind booth_mul_apb booth_mul_assertions u_assert (
    .clk, .reset, .apb_req, .apb_rsp, .busy, .done, .product
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 100 MHz
  end

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp);
      fail_cnt++;
    end
  endtask

  // Called 1 ns after an edge; returns 1 ns after the edge that ends the access phase
  task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata, output logic err);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);            // Mid access phase
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic wait_for_done();
    logic [APB_DATA_W-1:0] st;
    logic                  err;
    int                    polls;
    st    = '0;
    polls = 0;
    while (!st[STAT_DONE_BIT] && polls < 40)
    begin
      apb_access(1'b0, ADDR_STATUS, '0, st, err);
      polls++;
    end
    if (!st[STAT_DONE_BIT])
    begin
      $display("Timeout at %0t ns: the done bit never came up after a start", $time);
      other_cnt++;
    end
  endtask

  task automatic wait_to_cycle(input int target);
    int guard;
    guard = 0;
    while (cyc < target && guard < 64)
    begin
      @(posedge clk);
      #1;
      guard++;
    end
    if (cyc != target)
    begin
      $display("Timeout at %0t ns: edge count %0d not reached", $time, target);
      other_cnt++;
    end
  endtask

  task automatic read_result(output logic [63:0] res);
    logic [APB_DATA_W-1:0] lo;
    logic [APB_DATA_W-1:0] hi;
    logic [1:0]            errs;
    apb_access(1'b0, ADDR_RES_LO, '0, lo, errs[0]);
    apb_access(1'b0, ADDR_RES_HI, '0, hi, errs[1]);
    check_value(errs, 0, "result read pslverr");
    res = {hi, lo};   // RES_HI upper half must be 0
  endtask

  task automatic run_multiply(input logic [OPND_W-1:0] a, input logic [OPND_W-1:0] b,
                              input logic [PROD_W-1:0] exp, input string tag);
    logic [2:0]  errs;
    logic [31:0] unused;
    logic [63:0] res;
    apb_access(1'b1, ADDR_OP_A, 32'(a), unused, errs[0]);
    apb_access(1'b1, ADDR_OP_B, 32'(b), unused, errs[1]);
    apb_access(1'b1, ADDR_CTRL, 32'h1, unused, errs[2]);
    check_value(errs, 0, {tag, " setup pslverr"});
    wait_for_done();
    read_result(res);
    check_value(res, {16'h0, exp}, {tag, " product"});
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin
    int                    fd;
    int                    n;
    int                    i;
    int                    num_cases;
    int                    c0;
    string                 line;
    logic [OPND_W-1:0]     a;
    logic [OPND_W-1:0]     b;
    logic [PROD_W-1:0]     p;
    logic [APB_DATA_W-1:0] rd;
    logic                  err;
    logic [63:0]           res;
    logic [63:0]           res_hold;
    apb_req = '0;
    reset   = 1'b1;
    void'($urandom(3));
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset values
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    check_value({err, rd}, 0, "STATUS after reset");
    read_result(res);
    check_value(res, 0, "result after reset");

    // Directed pairs from the cases file
    fd = $fopen("sim/mul_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open sim/mul_cases.txt for reading");
      other_cnt++;
    end
    else
    begin
      num_cases = 0;
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 2 && line.substr(0, 1) != "//")   // Skip header and blanks
        begin
          n = $sscanf(line, "%h %h %h", a, b, p);
          if (n == 3)
          begin
            run_multiply(a, b, p, $sformatf("case %0d", num_cases));
            num_cases++;
          end
        end
      end
      $fclose(fd);
      check_value(num_cases, 16, "number of cases read");
    end

    // Random pairs against a plain multiply
    for (i = 0; i < 200; i++)
    begin
      a = OPND_W'($urandom);
      b = OPND_W'($urandom);
      p = PROD_W'(a) * PROD_W'(b);
      run_multiply(a, b, p, $sformatf("random %0d", i));
    end

    //////////////////////////////
    // Latency and busy refusals
    //////////////////////////////

    a = 24'hABCDEF;
    b = 24'h123456;
    p = PROD_W'(a) * PROD_W'(b);
    apb_access(1'b1, ADDR_OP_A, 32'(a), rd, err);
    apb_access(1'b1, ADDR_OP_B, 32'(b), rd, err);
    apb_access(1'b1, ADDR_CTRL, 32'h1, rd, err);
    c0 = cyc;                                        // Start-write edge
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    check_value(rd[1:0], 2'b01, "STATUS right after start");
    apb_access(1'b1, ADDR_OP_A, 32'h000777, rd, err);
    check_value(err, 1, "OP_A write while busy");
    apb_access(1'b1, ADDR_CTRL, 32'h1, rd, err);
    check_value(err, 1, "CTRL write while busy");
    wait_to_cycle(c0 + 13);                          // Read sees edge c0+14
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    check_value(rd[1:0], 2'b01, "STATUS 14 cycles after start");
    wait_for_done();
    read_result(res);
    check_value(res, {16'h0, p}, "product after refused writes");

    // Second run, done must be up at edge c0+15
    apb_access(1'b1, ADDR_CTRL, 32'h1, rd, err);
    c0 = cyc;
    wait_to_cycle(c0 + 14);
    apb_access(1'b0, ADDR_STATUS, '0, rd, err);
    check_value(rd[1:0], 2'b10, "STATUS 15 cycles after start");
    read_result(res_hold);
    check_value(res_hold, {16'h0, p}, "product of second run");

    // Unmapped read and read-only write
    apb_access(1'b0, 8'h18, '0, rd, err);
    check_value({err, rd}, {1'b1, 32'h0}, "unmapped read");
    apb_access(1'b1, ADDR_RES_LO, 32'hDEAD_BEEF, rd, err);
    check_value(err, 1, "RES_LO write");
    read_result(res);
    check_value(res, res_hold, "result after refused write");
    apb_access(1'b0, ADDR_OP_A, '0, rd, err);
    check_value({err, rd}, {1'b0, 8'h00, a}, "OP_A after refused writes");

    $display("Errors: %0d value, %0d other, %0d assertion",
             fail_cnt, other_cnt, uut.u_assert.fail_cnt);
    if (fail_cnt == 0 && other_cnt == 0 && uut.u_assert.fail_cnt == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- sim/mul_cases.txt
// op_a op_b product, all hex, one case per line
// op_a and op_b are 24 bits, product is 48 bits
000000 000000 000000000000
FFFFFF FFFFFF FFFFFE000001
555555 555555 1C71C6E38E39
AAAAAA 555555 38E38DC71C72
AAAAAA AAAAAA 71C71B8E38E4
000003 AAAAAA 000001FFFFFE
800000 800000 400000000000
800001 800001 400001000001
FFFFFF 800000 7FFFFF800000
800000 FFFFFF 7FFFFF800000
FFFFFF 000001 000000FFFFFF
000001 333333 000000333333
000003 CCCCCC 000002666664
F0F0F0 000002 000001E1E1E0
123456 000010 000001234560
FFFFFF 000000 000000000000

//--- src.f
source/booth_arith_pkg.sv
source/mul_apb_pkg.sv
source/booth_pp_gen.sv
source/csa_accumulator.sv
source/sparse_ks_adder.sv
source/mul_sequencer.sv
source/booth_digit_counter.sv
source/apb_mul_regs.sv
source/booth_mul_apb.sv
sim/booth_mul_assertions.sv
sim/booth_mul_tb.sv

//--- Bender.yml
package:
  name: booth_mul_apb

sources:
  - files:
      - source/booth_arith_pkg.sv
      - source/mul_apb_pkg.sv
      - source/booth_pp_gen.sv
      - source/csa_accumulator.sv
      - source/sparse_ks_adder.sv
      - source/mul_sequencer.sv
      - source/booth_digit_counter.sv
      - source/apb_mul_regs.sv
      - source/booth_mul_apb.sv
  - target: simulation
    files:
      - sim/booth_mul_assertions.sv
      - sim/booth_mul_tb.sv
